/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, result from the log.
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cpuTb \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/VcpuTb > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* sim.f */
+incdir+src
+incdir+test
src/isaPkg.sv
src/ctrlPkg.sv
src/controlUnit.sv
src/regSelect.sv
src/aluUnit.sv
src/datapath.sv
src/memoryRam.sv
src/cpuTop.sv
test/cpuTb.sv

/* src/aluUnit.sv */
`default_nettype none
`include "cpu_params.svh"

module aluUnit (
    input  wire ctrlPkg::aluOp_t  aluOp,
    input  wire [`WORD-1:0]       y,
    input  wire [`WORD-1:0]       b,
    output logic [2*`WORD-1:0]    z
);
    import ctrlPkg::*;

    localparam int ShW = $clog2(`WORD);

    logic [ShW-1:0]               sh;
    logic [`WORD-1:0]             hi;
    logic [`WORD-1:0]             low;
    logic signed [2*`WORD-1:0]    prod;
    logic signed [`WORD-1:0]      quot;
    logic signed [`WORD-1:0]      rem;

    assign sh   = b[ShW-1:0];
    assign prod = $signed(y) * $signed(b);
    assign quot = (b == '0) ? 'sd0 : $signed(y) / $signed(b);
    assign rem  = (b == '0) ? 'sd0 : $signed(y) % $signed(b);

    always_comb begin
        hi  = '0;
        low = '0;
        case (aluOp)
            aluAdd:  low = y + b;
            aluSub:  low = y - b;
            aluAnd:  low = y & b;
            aluOr:   low = y | b;
            aluShr:  low = y >> sh;
            aluShra: low = $signed(y) >>> sh;
            aluShl:  low = y << sh;
            aluRor:  low = (y >> sh) | (y << (`WORD - sh)); // sh of 0 leaves y.
            aluRol:  low = (y << sh) | (y >> (`WORD - sh));
            aluMul:  {hi, low} = prod;
            aluDiv: begin
                hi  = rem;  // remainder high, quotient low.
                low = quot;
            end
            aluNeg:  low = -b;
            aluNot:  low = ~b;
            default: low = '0;
        endcase
    end

    assign z = {hi, low};

endmodule

`default_nettype wire

/* src/controlUnit.sv */
`default_nettype none
`include "cpu_params.svh"

module controlUnit (
    input  wire                    clk,
    input  wire                    clr,
    input  wire                    stop,
    input  wire [`OPHI-`OPLO:0]    ir,
    input  wire                    con,
    output logic                   Read, Write, IncPC,
    output logic                   MARin, Zin, PCin, MDRin, IRin, Yin, HIin, LOin,
    output logic                   OutPortin, CONin, Rin,
    output logic                   PCout, Zhighout, Zlowout, MDRout, HIout, LOout,
    output logic                   BAout, InPortout, Cout, Rout,
    output logic                   Gra, Grb, Grc, linkSel,
    output ctrlPkg::aluOp_t        aluOp,
    output logic                   run
);
    import isaPkg::*;
    import ctrlPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;
    opcode_t    op;
    logic [9:0] busDrv;
    logic [27:0] allStrobes;

    assign op = opcode_t'(ir);

    function automatic aluOp_t opToAlu(opcode_t o);
        case (o)
            opSub, opSubi: return aluSub;
            opAnd, opAndi: return aluAnd;
            opOr, opOri:   return aluOr;
            opShr:         return aluShr;
            opShra:        return aluShra;
            opShl:         return aluShl;
            opRor:         return aluRor;
            opRol:         return aluRol;
            opMul:         return aluMul;
            opDiv:         return aluDiv;
            opNeg:         return aluNeg;
            opNot:         return aluNot;
            default:       return aluAdd;
        endcase
    endfunction

    always_ff @(posedge clk or posedge clr) begin
        if (clr)
            state <= stReset;
        else if (stop)
            state <= stHalt; // stop wins over any step.
        else
            state <= nextState;
    end

    always_comb begin
        nextState = stReset;
        case (state)
            stReset: nextState = stT0;
            stT0:    nextState = stT1;
            stT1:    nextState = stT2;
            stT2: begin
                // ir is forwarded from the bus in this cycle.
                case (op)
                    opAdd, opSub, opAnd, opOr, opShr,
                    opShra, opShl, opRor, opRol:        nextState = stAT3;
                    opNeg, opNot:                       nextState = stNT3;
                    opAddi, opSubi, opAndi, opOri:      nextState = stIT3;
                    opMul, opDiv:                       nextState = stMdT3;
                    opLd:                               nextState = stLdT3;
                    opLdi:                              nextState = stLdiT3;
                    opSt:                               nextState = stStT3;
                    opBranch:                           nextState = stBT3;
                    opJr:                               nextState = stJrT3;
                    opJal:                              nextState = stJalT3;
                    opIn:                               nextState = stInT3;
                    opOut:                              nextState = stOutT3;
                    opMfhi:                             nextState = stMfhiT3;
                    opMflo:                             nextState = stMfloT3;
                    opNop:                              nextState = stNopT3;
                    opHalt:                             nextState = stHalt;
                    default:                            nextState = stReset;
                endcase
            end
            stAT3:   nextState = stAT4;
            stAT4:   nextState = stAT5;
            stNT3:   nextState = stNT4;
            stMdT3:  nextState = stMdT4;
            stMdT4:  nextState = stMdT5;
            stMdT5:  nextState = stMdT6;
            stLdT3:  nextState = stLdT4;
            stLdT4:  nextState = stLdT5;
            stLdT5:  nextState = stLdT6;
            stLdT6:  nextState = stLdT7;
            stLdiT3: nextState = stLdiT4;
            stLdiT4: nextState = stLdiT5;
            stStT3:  nextState = stStT4;
            stStT4:  nextState = stStT5;
            stStT5:  nextState = stStT6;
            stStT6:  nextState = stStT7;
            stBT3:   nextState = stBT4;
            stBT4:   nextState = stBT5;
            stBT5:   nextState = stBT6;
            stIT3:   nextState = stIT4;
            stIT4:   nextState = stIT5;
            stJalT3: nextState = stJalT4;
            stHalt:  nextState = stHalt; // only clr leaves.
            default: nextState = stT0;   // last step of every instruction.
        endcase
    end

    // strobes decoded from the state alone.
    assign Read      = state inside {stT1, stLdT6};
    assign Write     = state == stStT7;
    assign IncPC     = state == stT0;
    assign MARin     = state inside {stT0, stLdT5, stStT5};
    assign MDRin     = state inside {stT1, stLdT6, stStT6};
    assign IRin      = state == stT2;
    assign Yin       = state inside {stAT3, stIT3, stMdT3, stLdT3, stLdiT3, stStT3, stBT4};
    assign Zin       = state inside {stAT4, stNT3, stIT4, stMdT4, stLdT4, stLdiT4,
                                     stStT4, stBT5};
    assign PCin      = state inside {stJrT3, stJalT4} || (state == stBT6 && con);
    assign HIin      = state == stMdT6;
    assign LOin      = state == stMdT5;
    assign OutPortin = state == stOutT3;
    assign CONin     = state == stBT3;
    assign Rin       = state inside {stAT5, stIT5, stNT4, stLdT7, stLdiT5, stJalT3,
                                     stInT3, stMfhiT3, stMfloT3};
    assign PCout     = state inside {stT0, stBT4, stJalT3};
    assign Zhighout  = state == stMdT6;
    assign Zlowout   = state inside {stAT5, stIT5, stNT4, stMdT5, stLdT5, stLdiT5,
                                     stStT5, stBT6};
    assign MDRout    = state inside {stT2, stLdT7};
    assign HIout     = state == stMfhiT3;
    assign LOout     = state == stMfloT3;
    assign BAout     = state inside {stLdT3, stLdiT3, stStT3};
    assign InPortout = state == stInT3;
    assign Cout      = state inside {stIT4, stLdT4, stLdiT4, stStT4, stBT5};
    assign Rout      = state inside {stAT3, stAT4, stIT3, stNT3, stMdT3, stMdT4, stStT6,
                                     stBT3, stJrT3, stJalT4, stOutT3};
    assign Gra       = state inside {stAT5, stIT5, stNT4, stLdT7, stLdiT5, stStT6, stBT3,
                                     stJrT3, stJalT4, stInT3, stOutT3, stMfhiT3, stMfloT3};
    assign Grb       = state inside {stAT3, stIT3, stNT3, stMdT3, stLdT3, stLdiT3, stStT3};
    assign Grc       = state inside {stAT4, stMdT4};
    assign linkSel   = state == stJalT3; // return address into r15.
    assign run       = state != stHalt;

    // address arithmetic in ld, ldi, st and branch uses add.
    assign aluOp = (state inside {stAT4, stNT3, stIT4, stMdT4}) ? opToAlu(op) : aluAdd;

    assign busDrv = {PCout, Zhighout, Zlowout, MDRout, HIout, LOout,
                     BAout, InPortout, Cout, Rout};
    assign allStrobes = {busDrv, Read, Write, IncPC, MARin, Zin, PCin, MDRin, IRin, Yin,
                         HIin, LOin, OutPortin, CONin, Rin, Gra, Grb, Grc, linkSel};

    busOneDriver: assert property (@(posedge clk) disable iff (clr) $onehot0(busDrv));

    // once halted, the CPU stays quiet until clr.
    haltHolds: assert property (@(posedge clk) disable iff (clr)
        state == stHalt |=> state == stHalt && !run && allStrobes == '0);

endmodule

`default_nettype wire

/* src/cpuTop.sv */
`default_nettype none
`include "cpu_params.svh"

module cpuTop (
    input  wire                             clk,
    input  wire                             clr,
    input  wire                             stop,
    input  wire [`WORD-1:0]                 inPort,
    input  wire                             loadEn,
    input  wire [$clog2(`MEMWORDS)-1:0]     loadAddr,
    input  wire [`WORD-1:0]                 loadData,
    output logic [`WORD-1:0]                outPort,
    output logic                            run
);
    import ctrlPkg::*;

    logic Read, Write, IncPC;
    logic MARin, Zin, PCin, MDRin, IRin, Yin, HIin, LOin, OutPortin, CONin, Rin;
    logic PCout, Zhighout, Zlowout, MDRout, HIout, LOout, BAout, InPortout, Cout, Rout;
    logic Gra, Grb, Grc, linkSel;
    logic con;
    aluOp_t aluOp;
    logic [`OPHI-`OPLO:0]            ir;
    logic [$clog2(`MEMWORDS)-1:0]    marAddr;
    logic [`WORD-1:0]                mdrData;
    logic [`WORD-1:0]                memData;

    controlUnit controlUnit_i (.*);

    datapath datapath_i (.*);

    memoryRam memoryRam_i (
        .clk,
        .Write,
        .addr     (marAddr),
        .wdata    (mdrData),
        .loadEn,
        .loadAddr,
        .loadData,
        .rdata    (memData)
    );

endmodule

`default_nettype wire

/* src/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define WORD     32
`define REGS     16
`define MEMWORDS 512

// instruction fields.
`define OPHI 31
`define OPLO 27
`define RAHI 26
`define RALO 23
`define RBHI 22
`define RBLO 19
`define RCHI 18
`define RCLO 15
`define CHI  18
`define CLO  0

`endif

/* src/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    // one clock per state.
    typedef enum logic [5:0] {
        stReset, stT0, stT1, stT2,
        stAT3, stAT4, stAT5,
        stNT3, stNT4,
        stMdT3, stMdT4, stMdT5, stMdT6,
        stLdT3, stLdT4, stLdT5, stLdT6, stLdT7,
        stLdiT3, stLdiT4, stLdiT5,
        stStT3, stStT4, stStT5, stStT6, stStT7,
        stBT3, stBT4, stBT5, stBT6,
        stIT3, stIT4, stIT5,
        stJrT3, stJalT3, stJalT4,
        stInT3, stOutT3, stMfhiT3, stMfloT3, stNopT3,
        stHalt
    } ctrlState_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr,
        aluShr, aluShra, aluShl, aluRor, aluRol,
        aluMul, aluDiv, aluNeg, aluNot
    } aluOp_t;

endpackage

`default_nettype wire

/* src/datapath.sv */
`default_nettype none
`include "cpu_params.svh"

module datapath (
    input  wire                             clk,
    input  wire                             clr,
    input  wire                             Read, Write, IncPC,
    input  wire                             MARin, Zin, PCin, MDRin, IRin, Yin,
    input  wire                             HIin, LOin, OutPortin, CONin, Rin,
    input  wire                             PCout, Zhighout, Zlowout, MDRout, HIout,
    input  wire                             LOout, BAout, InPortout, Cout, Rout,
    input  wire                             Gra, Grb, Grc, linkSel,
    input  wire ctrlPkg::aluOp_t            aluOp,
    input  wire [`WORD-1:0]                 memData,
    input  wire [`WORD-1:0]                 inPort,
    output logic [$clog2(`MEMWORDS)-1:0]    marAddr,
    output logic [`WORD-1:0]                mdrData,
    output logic [`OPHI-`OPLO:0]            ir,
    output logic [`WORD-1:0]                outPort,
    output logic                            con
);
    import isaPkg::*;

    logic [`WORD-1:0]              regs [`REGS];
    logic [`REGS-1:0]              regWe;
    logic [`REGS-1:0]              regRd;
    logic [`WORD-1:0]              cSext;
    logic [`WORD-1:0]              regBus;
    logic [`WORD-1:0]              bus;
    logic [`WORD-1:0]              pc, irReg, mdr, y, hi, lo;
    logic [$clog2(`MEMWORDS)-1:0]  mar;
    logic [2*`WORD-1:0]            z, aluZ;
    logic                          condMet;

    regSelect regSelect_i (.ir(irReg), .Gra, .Grb, .Grc, .Rin, .Rout, .BAout, .linkSel,
                           .regWe, .regRd, .cSext);

    aluUnit aluUnit_i (.aluOp, .y, .b(bus), .z(aluZ));

    always_comb begin
        regBus = '0;
        for (int i = 0; i < `REGS; i++)
            if (regRd[i])
                regBus |= regs[i];
    end

    // the sequencer enables one driver per state.
    always_comb begin
        if (PCout)          bus = pc;
        else if (Zhighout)  bus = z[2*`WORD-1:`WORD];
        else if (Zlowout)   bus = z[`WORD-1:0];
        else if (MDRout)    bus = mdr;
        else if (HIout)     bus = hi;
        else if (LOout)     bus = lo;
        else if (InPortout) bus = inPort;
        else if (Cout)      bus = cSext;
        else                bus = regBus; // zero when nothing is selected.
    end

    always_comb begin
        case (branchCond_t'(irReg[`RBLO+1:`RBLO]))
            brzr:    condMet = bus == '0;
            brnz:    condMet = bus != '0;
            brpl:    condMet = !bus[`WORD-1];
            default: condMet = bus[`WORD-1];
        endcase
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `REGS; i++)
            if (regWe[i])
                regs[i] <= bus;
        if (MARin) mar <= bus[$clog2(`MEMWORDS)-1:0];
        if (MDRin) mdr <= Read ? memData : bus;
        if (Yin)   y   <= bus;
        if (Zin)   z   <= aluZ;
        if (HIin)  hi  <= bus;
        if (LOin)  lo  <= bus;
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            pc      <= '0;
            irReg   <= '0;
            outPort <= '0;
            con     <= 1'b0;
        end else begin
            if (PCin)
                pc <= bus;
            else if (IncPC)
                pc <= pc + 1'b1; // word addressed.
            if (IRin)      irReg   <= bus;
            if (OutPortin) outPort <= bus;
            if (CONin)     con     <= condMet;
        end
    end

    // opcode forwarded in T2 so decode needs no extra cycle.
    assign ir      = IRin ? bus[`OPHI:`OPLO] : irReg[`OPHI:`OPLO];
    assign marAddr = mar;
    assign mdrData = mdr;

    noReadWrite: assert property (@(posedge clk) disable iff (clr) !(Read && Write));

endmodule

`default_nettype wire

/* src/isaPkg.sv */
`default_nettype none

package isaPkg;

    // opcode encodings of the instruction set.
    typedef enum logic [4:0] {
        opLd     = 5'd0,
        opLdi    = 5'd1,
        opSt     = 5'd2,
        opAdd    = 5'd3,
        opSub    = 5'd4,
        opAnd    = 5'd5,
        opOr     = 5'd6,
        opShr    = 5'd7,
        opShra   = 5'd8,
        opShl    = 5'd9,
        opRor    = 5'd10,
        opRol    = 5'd11,
        opAddi   = 5'd12,
        opAndi   = 5'd13,
        opOri    = 5'd14,
        opMul    = 5'd15,
        opDiv    = 5'd16,
        opNeg    = 5'd17,
        opNot    = 5'd18,
        opBranch = 5'd19,
        opJr     = 5'd20,
        opJal    = 5'd21,
        opIn     = 5'd22,
        opOut    = 5'd23,
        opMfhi   = 5'd24,
        opMflo   = 5'd25,
        opNop    = 5'd26,
        opHalt   = 5'd27,
        opSubi   = 5'd28
    } opcode_t;

    // branch kind in ir bits 20..19.
    typedef enum logic [1:0] {
        brzr = 2'd0,
        brnz = 2'd1,
        brpl = 2'd2,
        brmi = 2'd3
    } branchCond_t;

endpackage

`default_nettype wire

/* src/memoryRam.sv */
`default_nettype none
`include "cpu_params.svh"

module memoryRam (
    input  wire                             clk,
    input  wire                             Write,
    input  wire [$clog2(`MEMWORDS)-1:0]     addr,
    input  wire [`WORD-1:0]                 wdata,
    input  wire                             loadEn,
    input  wire [$clog2(`MEMWORDS)-1:0]     loadAddr,
    input  wire [`WORD-1:0]                 loadData,
    output logic [`WORD-1:0]                rdata
);
    logic [`WORD-1:0] mem [`MEMWORDS];

    always_ff @(posedge clk) begin
        if (loadEn)
            mem[loadAddr] <= loadData; // program load first.
        else if (Write)
            mem[addr] <= wdata;
    end

    assign rdata = mem[addr]; // same-cycle read for T1 and LD_T6.

endmodule

`default_nettype wire

/* src/regSelect.sv */
`default_nettype none
`include "cpu_params.svh"

module regSelect (
    input  wire [`WORD-1:0]  ir,
    input  wire              Gra, Grb, Grc,
    input  wire              Rin, Rout, BAout,
    input  wire              linkSel,
    output logic [`REGS-1:0] regWe,
    output logic [`REGS-1:0] regRd,
    output logic [`WORD-1:0] cSext
);
    logic [$clog2(`REGS)-1:0] field;
    logic [`REGS-1:0]         decoded;

    always_comb begin
        field = '0;
        if (Gra)
            field = ir[`RAHI:`RALO];
        else if (Grb)
            field = ir[`RBHI:`RBLO];
        else if (Grc)
            field = ir[`RCHI:`RCLO];
    end

    assign decoded = `REGS'(1) << field;

    assign regWe = linkSel ? (`REGS'(1) << (`REGS - 1)) : (Rin ? decoded : '0);

    // base register r0 reads as zero.
    assign regRd = (Rout || (BAout && field != '0)) ? decoded : '0;

    assign cSext = {{(`WORD - `CHI - 1){ir[`CHI]}}, ir[`CHI:`CLO]};

endmodule

`default_nettype wire

/* test/tbCases.svh */
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// each case has eight program words, an inPort value, a stop cycle (0 is none)
// and the outPort expected once run has fallen.
localparam int NumCases = 15;

logic [`WORD-1:0] prog   [NumCases][8];
logic [`WORD-1:0] inVal  [NumCases];
int               stopAt [NumCases];
logic [`WORD-1:0] expOut [NumCases];

task automatic buildCases();
    logic [`WORD-1:0] halt;
    halt = rw(opHalt, 0, 0, 0);
    for (int c = 0; c < NumCases; c++) begin
        for (int i = 0; i < 8; i++)
            prog[c][i] = halt;
        inVal[c]  = '0;
        stopAt[c] = 0;
    end
    // add, sub and and give 158, 42 and 10, then 10 | 100.
    prog[0] = '{cw(opLdi, 1, 0, 100), cw(opLdi, 2, 0, 58), rw(opAdd, 3, 1, 2),
                rw(opSub, 4, 1, 2), rw(opAnd, 5, 3, 4), rw(opOr, 6, 5, 1),
                rw(opOut, 6, 0, 0), halt};
    expOut[0] = 32'h0000006E;
    // -128 >>> 3 is -16, minus -5 is -11, masked by -49.
    prog[1] = '{cw(opLdi, 1, 0, -100), cw(opAddi, 2, 1, -28), cw(opLdi, 4, 0, 3),
                rw(opShra, 3, 2, 4), cw(opSubi, 5, 3, -5), cw(opAndi, 6, 5, -49),
                rw(opOut, 6, 0, 0), halt};
    expOut[1] = 32'hFFFFFFC5;
    // lo minus hi of -7 * 100000.
    prog[2] = '{cw(opLdi, 1, 0, -7), cw(opLdi, 2, 0, 100000), rw(opMul, 0, 1, 2),
                rw(opMfhi, 3, 0, 0), rw(opMflo, 4, 0, 0), rw(opSub, 5, 4, 3),
                rw(opOut, 5, 0, 0), halt};
    expOut[2] = 32'hFFF551A1;
    // in, store at 0x30+0x10, load from 0x40 directly, copy to 0x41 and back.
    prog[3] = '{rw(opIn, 1, 0, 0), cw(opLdi, 2, 0, 'h30), cw(opSt, 1, 2, 'h10),
                cw(opLd, 3, 0, 'h40), cw(opSt, 3, 2, 'h11), cw(opLd, 4, 2, 'h11),
                rw(opOut, 4, 0, 0), halt};
    inVal[3]  = $urandom;
    expOut[3] = inVal[3];
    // two branches each; a branch not taken adds 1 or 2.
    prog[4] = branchProg(0, brzr, brnz);
    expOut[4] = 32'd2;
    prog[5] = branchProg(5, brzr, brnz);
    expOut[5] = 32'd1;
    prog[6] = branchProg(5, brpl, brmi);
    expOut[6] = 32'd2;
    prog[7] = branchProg(-5, brpl, brmi);
    expOut[7] = 32'd1;
    // subroutine at word 4 sets r2 and returns through r15.
    prog[8] = '{cw(opLdi, 1, 0, 4), rw(opJal, 1, 0, 0), rw(opOut, 2, 0, 0), halt,
                cw(opLdi, 2, 0, 'h55), rw(opJr, 15, 0, 0), halt, halt};
    expOut[8] = 32'h00000055;
    // endless counter with one out every 17 cycles from cycle 17.
    prog[9] = '{cw(opLdi, 1, 0, 0), cw(opAddi, 1, 1, 1), rw(opOut, 1, 0, 0),
                cw(opBranch, 1, int'(brnz), -3), halt, halt, halt, halt};
    stopAt[9] = 60;
    expOut[9] = 32'd3;
    prog[10]   = prog[9];
    stopAt[10] = 30;
    expOut[10] = 32'd1;
    prog[11] = '{cw(opLdi, 1, 0, -'h7EFF), cw(opLdi, 2, 0, 8), rw(opRor, 3, 1, 2),
                 rw(opShl, 4, 3, 2), rw(opNeg, 5, 4, 0), rw(opNot, 6, 5, 0),
                 rw(opOut, 6, 0, 0), halt};
    expOut[11] = 32'hFFFF80FF;
    prog[12] = '{cw(opLdi, 1, 0, -'h7EFF), cw(opLdi, 2, 0, 12), rw(opRol, 3, 1, 2),
                 rw(opShr, 4, 3, 2), cw(opOri, 5, 4, -4096), rw(opNeg, 6, 5, 0),
                 rw(opOut, 6, 0, 0), halt};
    expOut[12] = 32'h00000EFF;
    // -100 / 7 truncates to quotient -14 and remainder -2.
    prog[13] = '{cw(opLdi, 1, 0, -100), cw(opLdi, 2, 0, 7), rw(opDiv, 0, 1, 2),
                 rw(opMfhi, 3, 0, 0), rw(opMflo, 4, 0, 0), rw(opSub, 5, 4, 3),
                 rw(opOut, 5, 0, 0), halt};
    expOut[13] = 32'hFFFFFFF4;
    prog[14] = '{cw(opLdi, 1, 0, 55), cw(opLdi, 2, 0, 0), rw(opDiv, 0, 1, 2),
                 rw(opMfhi, 3, 0, 0), rw(opMflo, 4, 0, 0), rw(opOr, 5, 3, 4),
                 rw(opOut, 5, 0, 0), halt};
    expOut[14] = 32'd0;
endtask

`endif

/* test/cpuTb.sv */
`default_nettype none
`include "cpu_params.svh"

module cpuTb;
    import isaPkg::*;

    typedef logic [`WORD-1:0] progRow_t [8];

    logic                          clk;
    logic                          clr;
    logic                          stop;
    logic [`WORD-1:0]              inPort;
    logic                          loadEn;
    logic [$clog2(`MEMWORDS)-1:0]  loadAddr;
    logic [`WORD-1:0]              loadData;
    logic [`WORD-1:0]              outPort;
    logic                          run;
    int                            cycleCount = 0;
    int                            runCycles;

    cpuTop cpuTop_i (.*);

    // register format with three register fields.
    function automatic logic [`WORD-1:0] rw(opcode_t op, int ra, int rb, int rc);
        rw = {op, 4'(ra), 4'(rb), 4'(rc), 15'b0};
    endfunction

    // constant format with a 19-bit signed C.
    function automatic logic [`WORD-1:0] cw(opcode_t op, int ra, int rb, int c);
        cw = {op, 4'(ra), 4'(rb), 19'(c)};
    endfunction

    function automatic progRow_t branchProg(int v, branchCond_t c1, branchCond_t c2);
        progRow_t p;
        p[0] = cw(opLdi, 1, 0, v);
        p[1] = cw(opLdi, 2, 0, 0);
        p[2] = cw(opBranch, 1, int'(c1), 1); // taken skips the next word.
        p[3] = cw(opAddi, 2, 2, 1);
        p[4] = cw(opBranch, 1, int'(c2), 1);
        p[5] = cw(opAddi, 2, 2, 2);
        p[6] = rw(opOut, 2, 0, 0);
        p[7] = rw(opHalt, 0, 0, 0);
        return p;
    endfunction

    `include "tbCases.svh"

    localparam int CycleLimit = NumCases * 200;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("timeout: the CPU did not stop within %0d cycles", CycleLimit);
            $display("TEST FAILED");
            $fatal(1, "simulation ended by the cycle limit");
        end
    end

    task automatic checkValue(string what, logic [`WORD-1:0] got, logic [`WORD-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // program goes in while the CPU is held in clr.
    task automatic loadAndReset(int c);
        clr    = 1'b1;
        stop   = 1'b0;
        inPort = inVal[c];
        for (int i = 0; i < 8; i++) begin
            loadEn   = 1'b1;
            loadAddr = ($clog2(`MEMWORDS))'(i);
            loadData = prog[c][i];
            @(posedge clk);
            #2;
        end
        loadEn = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        clr = 1'b0;
    endtask

    task automatic runCase(int c);
        runCycles = 0;
        checkValue($sformatf("case %0d run after reset", c), `WORD'(run), `WORD'(1));
        checkValue($sformatf("case %0d outPort after reset", c), outPort, '0);
        while (run === 1'b1) begin
            @(posedge clk);
            #2;
            runCycles++;
            // high for one cycle and seen at clock number stopAt.
            stop = (stopAt[c] != 0) && (runCycles == stopAt[c] - 1);
        end
        stop = 1'b0;
        checkValue($sformatf("case %0d run at halt", c), `WORD'(run), '0);
        checkValue($sformatf("case %0d outPort", c), outPort, expOut[c]);
        repeat (3) @(posedge clk);
        #2;
        checkValue($sformatf("case %0d run held low", c), `WORD'(run), '0);
        checkValue($sformatf("case %0d outPort held", c), outPort, expOut[c]);
    endtask

    initial begin
        clr      = 1'b1;
        stop     = 1'b0;
        inPort   = '0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        void'($urandom(31291));
        buildCases();
        for (int c = 0; c < NumCases; c++) begin
            loadAndReset(c);
            runCase(c);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
